// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module lsu_tb -f lsu_top.f
	./obj_dir/Vlsu_tb +verilator+error+limit+100 | tee /dev/stderr | grep "All tests passed" > /dev/null

clean:
	rm -rf obj_dir

// ==== hw/axi_read_engine.sv ====
`default_nettype none

module axi_read_engine (
	input logic clock,
	input logic reset,
	lsu_req_if.rd_eng req,
	input logic arready,
	input logic rvalid,
	input logic [lsu_pkg::id_w-1:0] rid,
	input logic [lsu_pkg::bus_w-1:0] rdata,
	output logic arvalid,
	output logic rready,
	output logic [lsu_pkg::addr_w-1:0] araddr,
	output logic [lsu_pkg::id_w-1:0] arid,
	output logic [lsu_pkg::bus_w-1:0] first_beat,
	output logic rd_done
);

	lsu_pkg::rd_state_e state;
	lsu_pkg::rd_state_e next_state;
	logic start;
	logic rsp_ok;
	// second half of a split load in progress
	logic second;

	assign start = req.busy && lsu_pkg::is_load(req.op);
	// responses carrying another ID are dropped
	assign rsp_ok = rvalid && rready && (rid == req.id);

	always_comb begin
		next_state = state;
		case (state)
			lsu_pkg::rd_idle:
				if (start)
					next_state = lsu_pkg::rd_wait_arready;
			lsu_pkg::rd_wait_arready:
				if (arready)
					next_state = lsu_pkg::rd_wait_rvalid;
			lsu_pkg::rd_wait_rvalid:
				if (rsp_ok) begin
					if (req.split && !second)
						next_state = lsu_pkg::rd_idle2;
					else
						next_state = lsu_pkg::rd_shaked_r;
				end
			lsu_pkg::rd_shaked_r:
				next_state = lsu_pkg::rd_idle;
			lsu_pkg::rd_idle2:
				next_state = lsu_pkg::rd_wait_arready;
			default:
				next_state = lsu_pkg::rd_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= lsu_pkg::rd_idle;
			arvalid <= 1'b0;
			rready <= 1'b0;
			second <= 1'b0;
		end else begin
			state <= next_state;
			arvalid <= (next_state == lsu_pkg::rd_wait_arready);
			rready <= (next_state == lsu_pkg::rd_wait_rvalid);
			if (next_state == lsu_pkg::rd_idle2)
				second <= 1'b1;
			else if (state == lsu_pkg::rd_shaked_r)
				second <= 1'b0;
		end
	end

	// low word of a split load, kept until the high word arrives
	always_ff @(posedge clock) begin
		if (rsp_ok && req.split && !second)
			first_beat <= rdata;
	end

	assign araddr = {req.addr[lsu_pkg::addr_w-1:3], 3'b000}
		+ {{(lsu_pkg::addr_w-4){1'b0}}, second, 3'b000};
	assign arid = req.id;
	assign rd_done = (state == lsu_pkg::rd_shaked_r);

endmodule

`default_nettype wire

// ==== hw/axi_write_engine.sv ====
`default_nettype none

module axi_write_engine (
	input logic clock,
	input logic reset,
	lsu_req_if.wr_eng req,
	input logic awready,
	input logic wready,
	input logic bvalid,
	input logic [lsu_pkg::id_w-1:0] bid,
	output logic awvalid,
	output logic wvalid,
	output logic wlast,
	output logic bready,
	output logic [lsu_pkg::addr_w-1:0] awaddr,
	output logic [lsu_pkg::id_w-1:0] awid,
	output logic beat2_sel,
	output logic wr_done
);

	lsu_pkg::wr_state_e state;
	lsu_pkg::wr_state_e next_state;
	logic start;
	logic rsp_ok;

	assign start = req.busy && lsu_pkg::is_store(req.op);
	assign rsp_ok = bvalid && bready && (bid == req.id);

	// address, then data, then response, once per beat
	always_comb begin
		next_state = state;
		case (state)
			lsu_pkg::wr_idle:
				if (start)
					next_state = lsu_pkg::wr_wait_awready;
			lsu_pkg::wr_wait_awready:
				if (awready)
					next_state = lsu_pkg::wr_wait_wready;
			lsu_pkg::wr_wait_wready:
				if (wready)
					next_state = lsu_pkg::wr_wait_bvalid;
			lsu_pkg::wr_wait_bvalid:
				if (rsp_ok) begin
					if (req.split && !beat2_sel)
						next_state = lsu_pkg::wr_idle2;
					else
						next_state = lsu_pkg::wr_shaked_b;
				end
			lsu_pkg::wr_shaked_b:
				next_state = lsu_pkg::wr_idle;
			lsu_pkg::wr_idle2:
				next_state = lsu_pkg::wr_wait_awready;
			default:
				next_state = lsu_pkg::wr_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= lsu_pkg::wr_idle;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
			beat2_sel <= 1'b0;
		end else begin
			state <= next_state;
			awvalid <= (next_state == lsu_pkg::wr_wait_awready);
			wvalid <= (next_state == lsu_pkg::wr_wait_wready);
			bready <= (next_state == lsu_pkg::wr_wait_bvalid);
			if (next_state == lsu_pkg::wr_idle2)
				beat2_sel <= 1'b1;
			else if (state == lsu_pkg::wr_shaked_b)
				beat2_sel <= 1'b0;
		end
	end

	// every write is a single beat
	assign wlast = wvalid;

	assign awaddr = {req.addr[lsu_pkg::addr_w-1:3], 3'b000}
		+ {{(lsu_pkg::addr_w-4){1'b0}}, beat2_sel, 3'b000};
	assign awid = req.id;
	assign wr_done = (state == lsu_pkg::wr_shaked_b);

endmodule

`default_nettype wire

// ==== hw/load_extract.sv ====
`default_nettype none

module load_extract (
	lsu_req_if.align req,
	input logic [lsu_pkg::bus_w-1:0] first_beat,
	input logic [lsu_pkg::bus_w-1:0] rdata,
	output logic [lsu_pkg::data_w-1:0] load_result
);

	logic [2:0] offset;
	logic split;
	logic [2*lsu_pkg::bus_w-1:0] pair;
	logic [2*lsu_pkg::bus_w-1:0] shifted;
	logic [lsu_pkg::data_w-1:0] word;

	assign offset = req.addr[2:0];
	assign split = lsu_pkg::needs_split(req.op, offset);

	// high beat above the low one, so the access is contiguous
	assign pair = split ? {rdata, first_beat} : {rdata, rdata};
	assign shifted = pair >> {offset, 3'b000};
	assign word = shifted[lsu_pkg::data_w-1:0];

	always_comb begin
		case (req.op)
			lsu_pkg::op_lb:
				load_result = {{(lsu_pkg::data_w-8){word[7]}}, word[7:0]};
			lsu_pkg::op_lbu:
				load_result = {{(lsu_pkg::data_w-8){1'b0}}, word[7:0]};
			lsu_pkg::op_lh:
				load_result = {{(lsu_pkg::data_w-16){word[15]}}, word[15:0]};
			lsu_pkg::op_lhu:
				load_result = {{(lsu_pkg::data_w-16){1'b0}}, word[15:0]};
			default:
				load_result = word;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/lsu_issue_stage.sv ====
`default_nettype none

module lsu_issue_stage (
	input logic clock,
	input logic reset,
	input logic req_valid,
	input lsu_pkg::mem_op_e req_op,
	input logic [lsu_pkg::addr_w-1:0] req_addr,
	input logic [lsu_pkg::data_w-1:0] req_wdata,
	input logic [lsu_pkg::reg_w-1:0] req_rd,
	input logic rd_done,
	input logic wr_done,
	input logic [lsu_pkg::data_w-1:0] load_result,
	output logic allowin,
	output logic done,
	output logic rf_wen,
	output logic [lsu_pkg::reg_w-1:0] rf_waddr,
	output logic [lsu_pkg::data_w-1:0] rf_wdata,
	lsu_req_if.stage req
);

	logic [lsu_pkg::id_w-1:0] id_cnt;
	logic ready_go;
	logic accept;

	// free-running transaction ID
	always_ff @(posedge clock) begin
		if (reset)
			id_cnt <= '0;
		else
			id_cnt <= id_cnt + 1'b1;
	end

	always_comb begin
		if (lsu_pkg::is_load(req.op))
			ready_go = rd_done;
		else if (lsu_pkg::is_store(req.op))
			ready_go = wr_done;
		else
			ready_go = 1'b1;
	end

	assign allowin = !req.busy || ready_go;
	assign accept = req_valid && allowin;

	always_ff @(posedge clock) begin
		if (reset)
			req.busy <= 1'b0;
		else if (allowin)
			req.busy <= req_valid;
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			req.op <= req_op;
			req.addr <= req_addr;
			req.wdata <= req_wdata;
			req.id <= id_cnt;
			req.split <= lsu_pkg::needs_split(req_op, req_addr[2:0]);
			rf_waddr <= req_rd;
		end
	end

	// the last r beat is on the bus one cycle before rd_done
	always_ff @(posedge clock) begin
		if (req.busy)
			rf_wdata <= load_result;
	end

	assign done = req.busy && ready_go;
	assign rf_wen = done && lsu_pkg::is_load(req.op);

endmodule

`default_nettype wire

// ==== hw/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

	localparam int data_w = 32;
	localparam int bus_w = 64;
	localparam int strb_w = 8;
	localparam int addr_w = 32;
	localparam int reg_w = 5;
	localparam int id_w = 4;
	// axsize code for a full 8-byte beat
	localparam logic [2:0] size_8b = 3'd3;

	typedef enum logic [3:0] {
		op_none = 4'd0,
		op_lb = 4'd1,
		op_lbu = 4'd2,
		op_lh = 4'd3,
		op_lhu = 4'd4,
		op_lw = 4'd5,
		op_sb = 4'd6,
		op_sh = 4'd7,
		op_sw = 4'd8
	} mem_op_e;

	typedef enum logic [2:0] {
		rd_idle = 3'd0,
		rd_wait_arready = 3'd1,
		rd_wait_rvalid = 3'd2,
		rd_shaked_r = 3'd3,
		rd_idle2 = 3'd4
	} rd_state_e;

	typedef enum logic [2:0] {
		wr_idle = 3'd0,
		wr_wait_awready = 3'd1,
		wr_wait_wready = 3'd2,
		wr_wait_bvalid = 3'd3,
		wr_shaked_b = 3'd4,
		wr_idle2 = 3'd5
	} wr_state_e;

	function automatic logic is_load(mem_op_e op);
		return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
	endfunction

	function automatic logic is_store(mem_op_e op);
		return op inside {op_sb, op_sh, op_sw};
	endfunction

	function automatic logic [3:0] access_bytes(mem_op_e op);
		case (op)
			op_lh, op_lhu, op_sh: return 4'd2;
			op_lw, op_sw: return 4'd4;
			default: return 4'd1;
		endcase
	endfunction

	// true when the access runs past the end of its 8-byte word
	function automatic logic needs_split(mem_op_e op, logic [2:0] offset);
		return ({1'b0, offset} + access_bytes(op)) > 4'd8;
	endfunction

endpackage

`default_nettype wire

// ==== hw/lsu_req_if.sv ====
`default_nettype none

interface lsu_req_if;

	logic busy;
	lsu_pkg::mem_op_e op;
	logic [lsu_pkg::addr_w-1:0] addr;
	logic [lsu_pkg::data_w-1:0] wdata;
	// bus ID stamped when the request was accepted
	logic [lsu_pkg::id_w-1:0] id;
	logic split;

	modport stage (output busy, op, addr, wdata, id, split);

	modport rd_eng (input busy, op, addr, wdata, id, split);

	modport wr_eng (input busy, op, addr, wdata, id, split);

	modport align (input op, addr, wdata);

endinterface

`default_nettype wire

// ==== hw/lsu_top.sv ====
`default_nettype none

module lsu_top (
	input logic clock,
	input logic reset,
	input logic req_valid,
	input lsu_pkg::mem_op_e req_op,
	input logic [lsu_pkg::addr_w-1:0] req_addr,
	input logic [lsu_pkg::data_w-1:0] req_wdata,
	input logic [lsu_pkg::reg_w-1:0] req_rd,
	output logic allowin,
	output logic done,
	output logic rf_wen,
	output logic [lsu_pkg::reg_w-1:0] rf_waddr,
	output logic [lsu_pkg::data_w-1:0] rf_wdata,
	input logic arready,
	output logic arvalid,
	output logic [lsu_pkg::addr_w-1:0] araddr,
	output logic [lsu_pkg::id_w-1:0] arid,
	output logic [7:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic rready,
	input logic rvalid,
	input logic [lsu_pkg::bus_w-1:0] rdata,
	input logic [lsu_pkg::id_w-1:0] rid,
	input logic awready,
	output logic awvalid,
	output logic [lsu_pkg::addr_w-1:0] awaddr,
	output logic [lsu_pkg::id_w-1:0] awid,
	output logic [7:0] awlen,
	output logic [2:0] awsize,
	output logic [1:0] awburst,
	output logic wvalid,
	output logic [lsu_pkg::bus_w-1:0] wdata,
	output logic [lsu_pkg::strb_w-1:0] wstrb,
	output logic wlast,
	input logic wready,
	input logic bvalid,
	input logic [lsu_pkg::id_w-1:0] bid,
	output logic bready
);

	lsu_req_if req_bus ();

	logic rd_done;
	logic wr_done;
	logic beat2_sel;
	logic [lsu_pkg::bus_w-1:0] first_beat;
	logic [lsu_pkg::data_w-1:0] load_result;

	// single full-width beats only
	assign arlen = 8'd0;
	assign arburst = 2'd0;
	assign arsize = lsu_pkg::size_8b;
	assign awlen = 8'd0;
	assign awburst = 2'd0;
	assign awsize = lsu_pkg::size_8b;

	lsu_issue_stage u_stage (
		.clock(clock), .reset(reset),
		.req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
		.req_wdata(req_wdata), .req_rd(req_rd),
		.rd_done(rd_done), .wr_done(wr_done), .load_result(load_result),
		.allowin(allowin), .done(done), .rf_wen(rf_wen),
		.rf_waddr(rf_waddr), .rf_wdata(rf_wdata), .req(req_bus.stage)
	);

	axi_read_engine u_rd (
		.clock(clock), .reset(reset), .req(req_bus.rd_eng),
		.arready(arready), .rvalid(rvalid), .rid(rid), .rdata(rdata),
		.arvalid(arvalid), .rready(rready), .araddr(araddr), .arid(arid),
		.first_beat(first_beat), .rd_done(rd_done)
	);

	axi_write_engine u_wr (
		.clock(clock), .reset(reset), .req(req_bus.wr_eng),
		.awready(awready), .wready(wready), .bvalid(bvalid), .bid(bid),
		.awvalid(awvalid), .wvalid(wvalid), .wlast(wlast), .bready(bready),
		.awaddr(awaddr), .awid(awid), .beat2_sel(beat2_sel), .wr_done(wr_done)
	);

	store_lane_align u_st_align (
		.req(req_bus.align), .beat2_sel(beat2_sel), .wdata(wdata), .wstrb(wstrb)
	);

	load_extract u_ld_extract (
		.req(req_bus.align), .first_beat(first_beat), .rdata(rdata),
		.load_result(load_result)
	);

endmodule

`default_nettype wire

// ==== hw/store_lane_align.sv ====
`default_nettype none

module store_lane_align (
	lsu_req_if.align req,
	input logic beat2_sel,
	output logic [lsu_pkg::bus_w-1:0] wdata,
	output logic [lsu_pkg::strb_w-1:0] wstrb
);

	logic [2:0] offset;
	logic [lsu_pkg::bus_w-1:0] data64;
	logic [2*lsu_pkg::bus_w-1:0] data_rot;
	logic [lsu_pkg::strb_w-1:0] lane_mask;
	logic [2*lsu_pkg::strb_w-1:0] mask_rot;
	logic [lsu_pkg::strb_w-1:0] upper_lanes;

	assign offset = req.addr[2:0];

	// rotate left by the byte offset, wrapped bytes land in the low lanes
	assign data64 = {{(lsu_pkg::bus_w-lsu_pkg::data_w){1'b0}}, req.wdata};
	assign data_rot = {data64, data64} << {offset, 3'b000};
	assign wdata = data_rot[2*lsu_pkg::bus_w-1:lsu_pkg::bus_w];

	// one strobe per stored byte
	assign lane_mask = ~({lsu_pkg::strb_w{1'b1}} << lsu_pkg::access_bytes(req.op));
	assign mask_rot = {lane_mask, lane_mask} << offset;

	// lanes at or above the offset belong to the first beat
	assign upper_lanes = {lsu_pkg::strb_w{1'b1}} << offset;

	assign wstrb = beat2_sel
		? mask_rot[2*lsu_pkg::strb_w-1:lsu_pkg::strb_w] & ~upper_lanes
		: mask_rot[2*lsu_pkg::strb_w-1:lsu_pkg::strb_w] & upper_lanes;

endmodule

`default_nettype wire

// ==== lsu_top.f ====
hw/lsu_pkg.sv
hw/lsu_req_if.sv
hw/lsu_issue_stage.sv
hw/axi_read_engine.sv
hw/axi_write_engine.sv
hw/store_lane_align.sv
hw/load_extract.sv
hw/lsu_top.sv
verification/lsu_properties.sv
verification/lsu_tb.sv

// ==== verification/lsu_golden.txt ====
// opcode address store_data expected_load, all hex, one access per line
// opcodes 0 none, 1 lb, 2 lbu, 3 lh, 4 lhu, 5 lw, 6 sb, 7 sh, 8 sw
1 00000012 00000000 ffffff81
2 00000012 00000000 00000081
3 00000014 00000000 ffff968f
4 00000014 00000000 0000968f
5 00000018 00000000 c0b9b2ab
5 00000005 00000000 3b342d26
5 0000000e 00000000 7a736c65
5 0000001f 00000000 f1eae3dc
3 00000027 00000000 00001b14
0 00000000 00000000 00000000
6 00000021 000000a5 00000000
5 00000020 00000000 f8f1a5e3
7 0000002f 0000beef 00000000
5 0000002d 00000000 beef453e
3 00000030 00000000 00005abe
8 00000035 12345678 00000000
5 00000034 00000000 3456786f
5 00000037 00000000 99921234
8 00000008 cafef00d 00000000
7 0000000a 00001234 00000000
5 00000008 00000000 1234f00d

// ==== verification/lsu_properties.sv ====
`default_nettype none

module lsu_properties (
	input logic clock,
	input logic reset,
	input logic arvalid,
	input logic arready,
	input logic awvalid,
	input logic awready,
	input logic wvalid,
	input logic wlast,
	input logic done
);

	int fail_count = 0;

	// address valids hold until accepted
	assert property (@(posedge clock) disable iff (reset) arvalid && !arready |=> arvalid)
		else begin
			$error("arvalid dropped before arready");
			fail_count++;
		end

	assert property (@(posedge clock) disable iff (reset) awvalid && !awready |=> awvalid)
		else begin
			$error("awvalid dropped before awready");
			fail_count++;
		end

	// single-beat writes only
	assert property (@(posedge clock) disable iff (reset) wlast == wvalid)
		else begin
			$error("wlast differs from wvalid");
			fail_count++;
		end

	assert property (@(posedge clock) disable iff (reset) done |=> !done)
		else begin
			$error("done high for more than one cycle");
			fail_count++;
		end

	assert property (@(posedge clock) disable iff (reset) !(arvalid && awvalid))
		else begin
			$error("arvalid and awvalid high together");
			fail_count++;
		end

endmodule

bind lsu_top lsu_properties props0 (.*);

`default_nettype wire

// ==== verification/lsu_tb.sv ====
`default_nettype none

module lsu_tb;

	localparam int max_tests = 64;
	localparam int mem_bytes = 64;

	logic clock = 1'b0;
	logic reset;
	logic req_valid;
	lsu_pkg::mem_op_e req_op;
	logic [31:0] req_addr;
	logic [31:0] req_wdata;
	logic [4:0] req_rd;
	logic allowin;
	logic done;
	logic rf_wen;
	logic [4:0] rf_waddr;
	logic [31:0] rf_wdata;
	logic arready, arvalid, rready, rvalid;
	logic [31:0] araddr;
	logic [3:0] arid, rid;
	logic [7:0] arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;
	logic [63:0] rdata;
	logic awready, awvalid, wvalid, wlast, wready, bvalid, bready;
	logic [31:0] awaddr;
	logic [3:0] awid, bid;
	logic [7:0] awlen;
	logic [2:0] awsize;
	logic [1:0] awburst;
	logic [63:0] wdata;
	logic [7:0] wstrb;

	logic [7:0] mem [mem_bytes];
	logic [7:0] ref_mem [mem_bytes];
	logic [31:0] golden [4*max_tests];
	integer seed = 4;
	int n_tests = 0;
	int errors = 0;
	int ar_count, aw_count;
	logic [31:0] ar_first, ar_last, aw_first, aw_last;
	int done_count = 0;
	int wen_count = 0;

	lsu_top dut0 (.*);

	always #4 clock = ~clock;

	// done and rf_wen pulses over the whole run
	always @(negedge clock) begin
		if (!reset && done)
			done_count++;
		if (!reset && rf_wen)
			wen_count++;
	end

	function automatic int rand_delay();
		return int'($unsigned($random(seed)) % 4);
	endfunction

	function automatic int op_bytes(lsu_pkg::mem_op_e op);
		case (op)
			lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: return 2;
			lsu_pkg::op_lw, lsu_pkg::op_sw: return 4;
			default: return 1;
		endcase
	endfunction

	function automatic logic [63:0] beat_at(logic [31:0] addr);
		logic [63:0] beat;
		for (int b = 0; b < 8; b++)
			beat[8*b +: 8] = mem[{addr[5:3], 3'(b)}];
		return beat;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic note_failure(input string what);
		$display("error: %s", what);
		errors++;
	endtask

	// entered and left one time unit after a rising edge
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic send_read(input logic [3:0] id, input logic [63:0] data);
		idle_cycles(rand_delay());
		rid = id;
		rdata = data;
		rvalid = 1'b1;
		while (!rready)
			idle_cycles(1);
		@(posedge clock);
		#1 rvalid = 1'b0;
	endtask

	task automatic send_write_resp(input logic [3:0] id);
		idle_cycles(rand_delay());
		bid = id;
		bvalid = 1'b1;
		while (!bready)
			idle_cycles(1);
		@(posedge clock);
		#1 bvalid = 1'b0;
	endtask

	initial begin : read_model
		logic [31:0] addr;
		logic [3:0] id;
		arready = 1'b0;
		rvalid = 1'b0;
		rid = '0;
		rdata = '0;
		forever begin
			idle_cycles(1);
			if (!reset && arvalid) begin
				idle_cycles(rand_delay());
				addr = araddr;
				id = arid;
				ar_count++;
				if (ar_count == 1)
					ar_first = addr;
				ar_last = addr;
				arready = 1'b1;
				@(posedge clock);
				#1 arready = 1'b0;
				// now and then a response for some other transaction first
				if (($random(seed) & 3) == 0)
					send_read(id ^ 4'h1, 64'hdead_beef_dead_beef);
				send_read(id, beat_at(addr));
			end
		end
	end

	initial begin : write_model
		logic [31:0] addr;
		logic [63:0] data;
		logic [7:0] strb;
		logic [3:0] id;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bid = '0;
		for (int a = 0; a < mem_bytes; a++)
			mem[a] = 8'(a * 7 + 3);
		forever begin
			idle_cycles(1);
			if (!reset && awvalid) begin
				idle_cycles(rand_delay());
				addr = awaddr;
				id = awid;
				aw_count++;
				if (aw_count == 1)
					aw_first = addr;
				aw_last = addr;
				awready = 1'b1;
				@(posedge clock);
				#1 awready = 1'b0;
				idle_cycles(rand_delay());
				while (!wvalid)
					idle_cycles(1);
				data = wdata;
				strb = wstrb;
				wready = 1'b1;
				@(posedge clock);
				#1 wready = 1'b0;
				for (int b = 0; b < 8; b++)
					if (strb[b])
						mem[{addr[5:3], 3'(b)}] = data[8*b +: 8];
				if (($random(seed) & 3) == 0)
					send_write_resp(id ^ 4'h1);
				send_write_resp(id);
			end
		end
	end

	initial begin : run_tests
		lsu_pkg::mem_op_e op;
		logic [31:0] addr;
		logic [31:0] wr_val;
		logic [31:0] base;
		int nbytes;
		logic split;
		logic load;
		int loads;
		int lines;
		int errs_before;
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = lsu_pkg::op_none;
		req_addr = '0;
		req_wdata = '0;
		req_rd = '0;
		loads = 0;
		for (int a = 0; a < mem_bytes; a++)
			ref_mem[a] = 8'(a * 7 + 3);
		for (int i = 0; i < 4 * max_tests; i++)
			golden[i] = '1;
		$readmemh("verification/lsu_golden.txt", golden);
		lines = 0;
		while (lines < max_tests && golden[4*lines] != '1)
			lines++;
		n_tests = lines;
		if (n_tests == 0)
			note_failure("the golden file holds no tests");
		repeat (3) @(posedge clock);
		#1 reset = 1'b0;
		for (int i = 0; i < n_tests; i++) begin
			op = lsu_pkg::mem_op_e'(golden[4*i][3:0]);
			addr = golden[4*i+1];
			wr_val = golden[4*i+2];
			nbytes = op_bytes(op);
			split = (int'(addr[2:0]) + nbytes) > 8;
			base = {addr[31:3], 3'b000};
			load = op inside {lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_lh,
				lsu_pkg::op_lhu, lsu_pkg::op_lw};
			errs_before = errors;
			ar_count = 0;
			aw_count = 0;
			if (!allowin)
				note_failure("allowin low while the unit was idle");
			req_valid = 1'b1;
			req_op = op;
			req_addr = addr;
			req_wdata = wr_val;
			req_rd = 5'(i);
			@(posedge clock);
			#1 req_valid = 1'b0;
			while (!done)
				idle_cycles(1);
			compare_value("rf_wen", 32'(rf_wen), 32'(load));
			compare_value("ar handshakes", ar_count, load ? (split ? 2 : 1) : 0);
			if (load) begin
				loads++;
				compare_value("rf_waddr", 32'(rf_waddr), 32'(i % 32));
				compare_value("rf_wdata", rf_wdata, golden[4*i+3]);
				compare_value("araddr first", ar_first, base);
				compare_value("araddr last", ar_last, base + (split ? 32'd8 : 32'd0));
				// single 8-byte beats, no burst
				compare_value("arlen", 32'(arlen), 32'h0);
				compare_value("arsize", 32'(arsize), 32'h3);
				compare_value("arburst", 32'(arburst), 32'h0);
			end
			if (op inside {lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw}) begin
				compare_value("aw handshakes", aw_count, split ? 2 : 1);
				compare_value("awaddr first", aw_first, base);
				compare_value("awaddr last", aw_last, base + (split ? 32'd8 : 32'd0));
				compare_value("awlen", 32'(awlen), 32'h0);
				compare_value("awsize", 32'(awsize), 32'h3);
				compare_value("awburst", 32'(awburst), 32'h0);
				// little-endian bytes of the store data
				for (int k = 0; k < nbytes; k++)
					ref_mem[6'(addr + 32'(k))] = 8'(wr_val >> (8 * k));
			end else begin
				compare_value("aw handshakes", aw_count, 0);
			end
			$display("test %0d %s addr %h: %s", i, op.name(), addr,
				errors == errs_before ? "ok" : "FAILED");
			idle_cycles(1);
		end
		compare_value("done pulses", done_count, n_tests);
		compare_value("rf_wen pulses", wen_count, loads);
		for (int a = 0; a < mem_bytes; a++)
			compare_value($sformatf("mem[%0d]", a), 32'(mem[a]), 32'(ref_mem[a]));
		compare_value("assertion failures", dut0.props0.fail_count, 0);
		$display("%0d tests run, %0d errors", n_tests, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial begin : watchdog
		wait (n_tests > 0);
		repeat (n_tests * 200) @(posedge clock);
		$display("timeout: the tests did not finish within %0d cycles", n_tests * 200);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
